/* verilog/quarkCore_defs.svh */
/*
 * Quark core build constants
 * Reset vector, internal address width and cycle-counter width
 */
`ifndef QUARK_CORE_DEFS_SVH
`define QUARK_CORE_DEFS_SVH

// First fetch address after reset
`define QUARK_RESET_ADDR 32'h0000_0000

// Width of PC and address adders, upper bus bits stay zero
`define QUARK_ADDR_WIDTH 24

// Cycle counter width, zero-extended when read by RDCYCLE
`define QUARK_COUNTER_WIDTH 32

`endif

/* verilog/quarkPkg.sv */
/*
 * Quark core package
 * Data word, register index, opcode and sequencer state types,
 * plus the latched instruction word seen through its six RV32I formats
 */
package quarkPkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0] regIdx_t;

   // Instruction bits 6:2, bits 1:0 are always 11
   typedef enum logic [4:0] {
      load   = 5'b00000,
      aluImm = 5'b00100,
      auipc  = 5'b00101,
      store  = 5'b01000,
      aluReg = 5'b01100,
      lui    = 5'b01101,
      branch = 5'b11000,
      jalr   = 5'b11001,
      jal    = 5'b11011,
      system = 5'b11100
   } opcode_t;

   // One-hot sequencer states
   typedef enum logic [3:0] {
      fetchInstr   = 4'b0001,
      waitInstr    = 4'b0010,
      execute      = 4'b0100,
      waitAluOrMem = 4'b1000
   } seqState_t;

   // Format views of instruction bits 31:2, each 30 bits wide
   typedef struct packed {
      logic [6:0] funct7;
      regIdx_t    rs2;
      regIdx_t    rs1;
      logic [2:0] funct3;
      regIdx_t    rd;
      opcode_t    opcode;
   } rType_t;

   typedef struct packed {
      logic [11:0] imm11_0;
      regIdx_t     rs1;
      logic [2:0]  funct3;
      regIdx_t     rd;
      opcode_t     opcode;
   } iType_t;

   typedef struct packed {
      logic [6:0] imm11_5;
      regIdx_t    rs2;
      regIdx_t    rs1;
      logic [2:0] funct3;
      logic [4:0] imm4_0;
      opcode_t    opcode;
   } sType_t;

   typedef struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      regIdx_t    rs2;
      regIdx_t    rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      opcode_t    opcode;
   } bType_t;

   typedef struct packed {
      logic [19:0] imm31_12;
      regIdx_t     rd;
      opcode_t     opcode;
   } uType_t;

   typedef struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      regIdx_t    rd;
      opcode_t    opcode;
   } jType_t;

   typedef union packed {
      rType_t rType;
      iType_t iType;
      sType_t sType;
      bType_t bType;
      uType_t uType;
      jType_t jType;
   } instrWord_t;

endpackage

/* verilog/quarkExecIf.sv */
/*
 * Sequencer to ALU link
 * Latched instruction and operands go to the ALU, results, busy
 * and branch predicate come back
 */
`timescale 1ns/1ps

interface quarkExecIf;
   import quarkPkg::*;

   instrWord_t instr;
   // Operands, driven by the register file at the top level
   word_t      rs1;
   word_t      rs2;
   logic       aluStart;

   word_t      aluOut;
   word_t      aluPlus;
   logic       aluBusy;
   logic       predicate;

   modport seq (
      output instr, aluStart,
      input  rs1, rs2, aluOut, aluPlus, aluBusy, predicate
   );

   modport alu (
      input  instr, rs1, rs2, aluStart,
      output aluOut, aluPlus, aluBusy, predicate
   );

endinterface

/* verilog/quarkRegFile.sv */
/*
 * Quark register file
 * 31 writable 32-bit registers, x0 reads as zero
 * Operands are captured while the instruction word arrives
 */
`timescale 1ns/1ps

module quarkRegFile (
   input  logic             clk,
   input  logic             capture,
   input  quarkPkg::regIdx_t rs1Idx,
   input  quarkPkg::regIdx_t rs2Idx,
   input  logic             writeEn,
   input  quarkPkg::regIdx_t rdIdx,
   input  quarkPkg::word_t   writeData,
   output quarkPkg::word_t   rs1,
   output quarkPkg::word_t   rs2
);
   import quarkPkg::*;

   // No storage for x0
   word_t regs [1:31];

   always_ff @(posedge clk) begin
      if (writeEn && rdIdx != '0) begin
         regs[rdIdx] <= writeData;
      end
   end

   // Indices come straight off the memory read data
   always_ff @(posedge clk) begin
      if (capture) begin
         rs1 <= (rs1Idx == '0) ? '0 : regs[rs1Idx];
         rs2 <= (rs2Idx == '0) ? '0 : regs[rs2Idx];
      end
   end

   // Operand capture and write-back belong to different sequencer states
   captureWriteExclusive: assert property (@(posedge clk) !(capture && writeEn));

endmodule

/* verilog/quarkAlu.sv */
/*
 * Quark ALU
 * Shared adder, 33-bit subtract for compares, logic ops,
 * serial one-bit-per-cycle shifter and branch predicate
 */
`timescale 1ns/1ps

module quarkAlu (
   input logic clk,
   input logic reset,
   quarkExecIf.alu ex
);
   import quarkPkg::*;

   opcode_t    opcode;
   logic [2:0] funct3;
   logic       funct7b5;
   word_t      iImm;
   word_t      aluIn2;
   logic [32:0] aluMinus;
   logic       eq;
   logic       lt;
   logic       ltu;
   logic       isShift;
   word_t      shiftReg;
   logic [4:0] shamt;

   assign opcode   = ex.instr.rType.opcode;
   assign funct3   = ex.instr.rType.funct3;
   assign funct7b5 = ex.instr.rType.funct7[5];
   assign iImm     = {{20{ex.instr.iType.imm11_0[11]}}, ex.instr.iType.imm11_0};

   // Register operand for reg-reg ops and branches, immediate otherwise
   assign aluIn2 = (opcode == aluReg || opcode == branch) ? ex.rs2 : iImm;

   // Also the JALR target and load/store base in the reference
   assign ex.aluPlus = ex.rs1 + aluIn2;

   // Bit 32 is the borrow, set when rs1 < in2 unsigned
   assign aluMinus = {1'b0, ex.rs1} - {1'b0, aluIn2};
   assign ltu = aluMinus[32];
   // Sign bits differ so rs1 is less exactly when it is negative
   assign lt  = (ex.rs1[31] ^ aluIn2[31]) ? ex.rs1[31] : aluMinus[32];
   assign eq  = (aluMinus[31:0] == '0);

   // SLL is 001, SRL/SRA is 101
   assign isShift = (funct3[1:0] == 2'b01);

   always_comb begin
      case (funct3)
         3'b000: begin
            // funct7 bit 5 overlaps the I-immediate, so SUB needs aluReg too
            if (opcode == aluReg && funct7b5) begin
               ex.aluOut = aluMinus[31:0];
            end else begin
               ex.aluOut = ex.aluPlus;
            end
         end
         3'b010:  ex.aluOut = {31'b0, lt};
         3'b011:  ex.aluOut = {31'b0, ltu};
         3'b100:  ex.aluOut = ex.rs1 ^ aluIn2;
         3'b110:  ex.aluOut = ex.rs1 | aluIn2;
         3'b111:  ex.aluOut = ex.rs1 & aluIn2;
         default: ex.aluOut = shiftReg;
      endcase
   end

   // Shift counter, busy while non-zero
   always_ff @(posedge clk) begin
      if (!reset) begin
         shamt <= '0;
      end else if (ex.aluStart && isShift) begin
         shamt <= aluIn2[4:0];
      end else if (|shamt) begin
         shamt <= shamt - 5'd1;
      end
   end

   // One bit per cycle, arithmetic right shift fills with the sign
   always_ff @(posedge clk) begin
      if (ex.aluStart && isShift) begin
         shiftReg <= ex.rs1;
      end else if (|shamt) begin
         if (funct3 == 3'b001) begin
            shiftReg <= {shiftReg[30:0], 1'b0};
         end else begin
            shiftReg <= {funct7b5 & shiftReg[31], shiftReg[31:1]};
         end
      end
   end

   assign ex.aluBusy = |shamt;

   // BEQ BNE BLT BGE BLTU BGEU
   always_comb begin
      case (funct3)
         3'b000:  ex.predicate = eq;
         3'b001:  ex.predicate = !eq;
         3'b100:  ex.predicate = lt;
         3'b101:  ex.predicate = !lt;
         3'b110:  ex.predicate = ltu;
         3'b111:  ex.predicate = !ltu;
         default: ex.predicate = 1'b0;
      endcase
   end

   // The sequencer must wait out a running shift before the next start
   noStartWhileBusy: assert property (
      @(posedge clk) disable iff (!reset) ex.aluStart |-> !ex.aluBusy
   );

endmodule

/* verilog/quarkLoadStore.sv */
/*
 * Quark load/store alignment
 * Extracts byte or halfword loads with optional sign extension,
 * replicates store data into byte lanes and builds the write mask
 */
`timescale 1ns/1ps

module quarkLoadStore (
   input  logic [2:0]      funct3,
   input  logic [1:0]      addrLow,
   input  quarkPkg::word_t storeData,
   input  logic            storeNow,
   input  quarkPkg::word_t memRdata,
   output quarkPkg::word_t memWdata,
   output logic [3:0]      memWmask,
   output quarkPkg::word_t loadData
);

   logic        byteAccess;
   logic        halfAccess;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;
   logic [3:0]  storeMask;

   // funct3 low bits give size: 00 byte, 01 halfword, 10 word
   assign byteAccess = (funct3[1:0] == 2'b00);
   assign halfAccess = (funct3[1:0] == 2'b01);

   // Address bit 1 picks the halfword, bit 0 the byte inside it
   assign loadHalf = addrLow[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = addrLow[0] ? loadHalf[15:8] : loadHalf[7:0];

   // LBU and LHU have funct3 bit 2 set
   assign loadSign = !funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);

   always_comb begin
      if (byteAccess) begin
         loadData = {{24{loadSign}}, loadByte};
      end else if (halfAccess) begin
         loadData = {{16{loadSign}}, loadHalf};
      end else begin
         loadData = memRdata;
      end
   end

   // Low byte and halfword copied into every lane they may land in
   assign memWdata[7:0]   = storeData[7:0];
   assign memWdata[15:8]  = addrLow[0] ? storeData[7:0] : storeData[15:8];
   assign memWdata[23:16] = addrLow[1] ? storeData[7:0] : storeData[23:16];
   assign memWdata[31:24] = addrLow[0] ? storeData[7:0] :
                            addrLow[1] ? storeData[15:8] : storeData[31:24];

   always_comb begin
      if (byteAccess) begin
         storeMask = 4'b0001 << addrLow;
      end else if (halfAccess) begin
         storeMask = addrLow[1] ? 4'b1100 : 4'b0011;
      end else begin
         storeMask = 4'b1111;
      end
   end

   // Mask only during the store's execute cycle
   assign memWmask = storeNow ? storeMask : 4'b0000;

endmodule

/* verilog/quarkSequencer.sv */
/*
 * Quark sequencer
 * One-hot fetch/execute FSM, program counter, instruction latch,
 * bus address select, write-back select and cycle counter
 */
`timescale 1ns/1ps
`include "quarkCore_defs.svh"

module quarkSequencer (
   input  logic            clk,
   input  logic            reset,
   quarkExecIf.seq         ex,
   input  quarkPkg::word_t memRdata,
   input  logic            memRbusy,
   input  logic            memWbusy,
   input  quarkPkg::word_t loadData,
   output quarkPkg::word_t memAddr,
   output logic            memRstrb,
   output logic            capture,
   output logic            writeEn,
   output quarkPkg::word_t writeData,
   output logic            storeNow
);
   import quarkPkg::*;

   localparam word_t ResetAddr = `QUARK_RESET_ADDR;

   seqState_t  state;
   instrWord_t instr;
   opcode_t    opcode;
   logic [`QUARK_ADDR_WIDTH-1:0] pc;
   logic [`QUARK_ADDR_WIDTH-1:0] pcPlus4;
   logic [`QUARK_ADDR_WIDTH-1:0] pcPlusImm;
   logic [`QUARK_ADDR_WIDTH-1:0] lsAddr;
   logic [`QUARK_COUNTER_WIDTH-1:0] cycles;
   word_t iImm, sImm, bImm, uImm, jImm;
   logic  isAlu;
   logic  needToWait;

   assign opcode = instr.rType.opcode;
   assign ex.instr = instr;

   // Immediates rebuilt from each format view
   assign iImm = {{20{instr.iType.imm11_0[11]}}, instr.iType.imm11_0};
   assign sImm = {{20{instr.sType.imm11_5[6]}}, instr.sType.imm11_5, instr.sType.imm4_0};
   assign bImm = {{19{instr.bType.imm12}}, instr.bType.imm12, instr.bType.imm11,
                  instr.bType.imm10_5, instr.bType.imm4_1, 1'b0};
   assign uImm = {instr.uType.imm31_12, 12'b0};
   assign jImm = {{11{instr.jType.imm20}}, instr.jType.imm20, instr.jType.imm19_12,
                  instr.jType.imm11, instr.jType.imm10_1, 1'b0};

   assign pcPlus4 = pc + 4;
   // Shared by JAL, AUIPC and branches
   assign pcPlusImm = pc + ((opcode == jal)   ? jImm[`QUARK_ADDR_WIDTH-1:0] :
                            (opcode == auipc) ? uImm[`QUARK_ADDR_WIDTH-1:0] :
                                                bImm[`QUARK_ADDR_WIDTH-1:0]);
   // Separate load/store address adder
   assign lsAddr = ex.rs1[`QUARK_ADDR_WIDTH-1:0] +
                   ((opcode == store) ? sImm[`QUARK_ADDR_WIDTH-1:0] :
                                        iImm[`QUARK_ADDR_WIDTH-1:0]);

   assign memAddr = (state == fetchInstr || state == waitInstr) ? word_t'(pc) :
                                                                  word_t'(lsAddr);

   assign isAlu = (opcode == aluImm) || (opcode == aluReg);
   // Shifts are funct3 001 and 101
   assign needToWait = (opcode == load) || (opcode == store) ||
                       (isAlu && instr.rType.funct3[1:0] == 2'b01);

   assign memRstrb    = (state == fetchInstr) || (state == execute && opcode == load);
   assign storeNow    = (state == execute) && (opcode == store);
   assign ex.aluStart = (state == execute) && isAlu;
   assign capture     = (state == waitInstr) && !memRbusy;
   assign writeEn     = (opcode != branch) && (opcode != store) &&
                        (state == execute || state == waitAluOrMem);

   always_comb begin
      case (opcode)
         system:        writeData = word_t'(cycles);
         lui:           writeData = uImm;
         aluImm,
         aluReg:        writeData = ex.aluOut;
         auipc:         writeData = word_t'(pcPlusImm);
         jal, jalr:     writeData = word_t'(pcPlus4);
         load:          writeData = loadData;
         default:       writeData = '0;
      endcase
   end

   // Instruction arrives on the same edge the operands are read
   always_ff @(posedge clk) begin
      if (capture) begin
         instr <= memRdata[31:2];
      end
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         // Start by waiting for the memory to go idle
         state <= waitAluOrMem;
         pc    <= ResetAddr[`QUARK_ADDR_WIDTH-1:0];
      end else begin
         case (state)
            fetchInstr: state <= waitInstr;
            waitInstr: begin
               if (!memRbusy) begin
                  state <= execute;
               end
            end
            execute: begin
               if (opcode == jalr) begin
                  pc <= {ex.aluPlus[`QUARK_ADDR_WIDTH-1:1], 1'b0};
               end else if (opcode == jal || (opcode == branch && ex.predicate)) begin
                  pc <= pcPlusImm;
               end else begin
                  pc <= pcPlus4;
               end
               state <= needToWait ? waitAluOrMem : fetchInstr;
            end
            default: begin
               if (!ex.aluBusy && !memRbusy && !memWbusy) begin
                  state <= fetchInstr;
               end
            end
         endcase
      end
   end

   // Free-running, read by RDCYCLE
   always_ff @(posedge clk) begin
      if (!reset) begin
         cycles <= '0;
      end else begin
         cycles <= cycles + 1'b1;
      end
   end

   stateOneHot: assert property (@(posedge clk) disable iff (!reset) $onehot(state));

endmodule

/* verilog/quarkCore.sv */
/*
 * Quark RV32I core top level
 * Connects sequencer, register file, ALU and load/store unit
 * to a plain memory bus with read strobe, write mask and busy inputs
 */
`timescale 1ns/1ps

module quarkCore (
   input  logic        clk,
   input  logic        reset,
   output logic [31:0] memAddr,
   output logic [31:0] memWdata,
   output logic [3:0]  memWmask,
   input  logic [31:0] memRdata,
   output logic        memRstrb,
   input  logic        memRbusy,
   input  logic        memWbusy
);
   import quarkPkg::*;

   logic  capture;
   logic  writeEn;
   logic  storeNow;
   word_t writeData;
   word_t loadData;

   quarkExecIf ex ();

   // Operand indices taken from the word still on the bus
   quarkRegFile regFile_i (
      .clk       (clk),
      .capture   (capture),
      .rs1Idx    (memRdata[19:15]),
      .rs2Idx    (memRdata[24:20]),
      .writeEn   (writeEn),
      .rdIdx     (ex.instr.rType.rd),
      .writeData (writeData),
      .rs1       (ex.rs1),
      .rs2       (ex.rs2)
   );

   quarkAlu alu_i (
      .clk   (clk),
      .reset (reset),
      .ex    (ex.alu)
   );

   quarkLoadStore loadStore_i (
      .funct3    (ex.instr.rType.funct3),
      .addrLow   (memAddr[1:0]),
      .storeData (ex.rs2),
      .storeNow  (storeNow),
      .memRdata  (memRdata),
      .memWdata  (memWdata),
      .memWmask  (memWmask),
      .loadData  (loadData)
   );

   quarkSequencer sequencer_i (
      .clk       (clk),
      .reset     (reset),
      .ex        (ex.seq),
      .memRdata  (memRdata),
      .memRbusy  (memRbusy),
      .memWbusy  (memWbusy),
      .loadData  (loadData),
      .memAddr   (memAddr),
      .memRstrb  (memRstrb),
      .capture   (capture),
      .writeEn   (writeEn),
      .writeData (writeData),
      .storeNow  (storeNow)
   );

endmodule

/* testbench/quarkCoreTb.sv */
/*
 * Quark core testbench
 * Word-array memory with optional random busy stalls, a small
 * instruction encoder and directed tests for ALU, shifts, control
 * flow, sub-word access and bus back-pressure
 */
`timescale 1ns/1ps
`include "quarkCore_defs.svh"

module quarkCoreTb;
   import quarkPkg::*;

   localparam int ClkPeriod = 4;
   // Instructions executed over all tests, rounded up
   localparam int TotalInstr = 360;
   localparam word_t ResultBase = 32'h0000_0400;
   localparam word_t DataBase = 32'h0000_0600;

   // RV32I major opcodes
   localparam logic [6:0] OpLoad = 7'h03;
   localparam logic [6:0] OpImm = 7'h13;
   localparam logic [6:0] OpAuipc = 7'h17;
   localparam logic [6:0] OpStore = 7'h23;
   localparam logic [6:0] OpReg = 7'h33;
   localparam logic [6:0] OpLui = 7'h37;
   localparam logic [6:0] OpBranch = 7'h63;
   localparam logic [6:0] OpJalr = 7'h67;
   localparam logic [6:0] OpJal = 7'h6f;
   localparam logic [6:0] OpSystem = 7'h73;

   logic       clk;
   logic       reset;
   word_t      memAddr;
   word_t      memWdata;
   logic [3:0] memWmask;
   word_t      memRdata;
   logic       memRstrb;
   logic       memRbusy;
   logic       memWbusy;

   // 4 KB memory, program from 0, results at 0x400, data at 0x600
   word_t mem [0:1023];
   logic  stallOn;
   int    rdWait;
   int    wrWait;
   word_t rdHold;
   word_t progPc;
   word_t resOff;
   // Stores seen in the result area
   word_t      seenAddr [$];
   word_t      seenData [$];
   logic [3:0] seenMask [$];
   // Expected stores, lanes selects the compared bytes
   word_t      expAddr [$];
   word_t      expData [$];
   word_t      expLanes [$];
   logic [3:0] expMask [$];

   quarkCore dut_i (
      .clk      (clk),
      .reset    (reset),
      .memAddr  (memAddr),
      .memWdata (memWdata),
      .memWmask (memWmask),
      .memRdata (memRdata),
      .memRstrb (memRstrb),
      .memRbusy (memRbusy),
      .memWbusy (memWbusy)
   );

   initial clk = 1'b0;
   always #(ClkPeriod / 2) clk = ~clk;

   task automatic checkWord(word_t actual, word_t expected, string what);
      if (actual !== expected) begin
         $display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
                  $time, what, actual, expected);
         $display("CHECKS FAILED");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic checkMask(logic [3:0] actual, logic [3:0] expected, string what);
      if (actual !== expected) begin
         $display("CHECK FAILED at %0t ns: %s, got %b, expected %b",
                  $time, what, actual, expected);
         $display("CHECKS FAILED");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic requireInModel(word_t addr);
      if (addr >= 32'h0000_1000) begin
         $display("Bus access at address %h lies outside the memory model", addr);
         $display("CHECKS FAILED");
         $fatal(1, "bad bus address");
      end
   endtask

   // Memory model, samples on the falling edge when core outputs are settled
   always @(negedge clk) begin
      if (!reset) begin
         rdWait = 0;
         wrWait = 0;
         memRbusy = 1'b0;
         memWbusy = 1'b0;
      end else begin
         if (rdWait > 0) begin
            rdWait--;
            if (rdWait == 0) begin
               memRdata = rdHold;
               memRbusy = 1'b0;
            end
         end
         if (wrWait > 0) begin
            wrWait--;
            if (wrWait == 0) begin
               memWbusy = 1'b0;
            end
         end
         if (memRstrb) begin
            requireInModel(memAddr);
            rdHold = mem[memAddr[11:2]];
            rdWait = stallOn ? int'($urandom % 4) : 0;
            // Garbage on the bus until the stall ends
            memRdata = (rdWait == 0) ? rdHold : ~rdHold;
            memRbusy = (rdWait != 0);
         end
         if (memWmask != 4'b0000) begin
            requireInModel(memAddr);
            for (int b = 0; b < 4; b++) begin
               if (memWmask[b]) begin
                  mem[memAddr[11:2]][8*b +: 8] = memWdata[8*b +: 8];
               end
            end
            if (memAddr >= ResultBase && memAddr < DataBase) begin
               seenAddr.push_back(memAddr);
               seenData.push_back(memWdata);
               seenMask.push_back(memWmask);
            end
            wrWait = stallOn ? int'($urandom % 4) : 0;
            memWbusy = (wrWait != 0);
         end
      end
   end

   // Instruction formats as laid out in the RV32I spec
   function automatic word_t rFormat(logic [6:0] f7, regIdx_t rs2, regIdx_t rs1,
                                     logic [2:0] f3, regIdx_t rd, logic [6:0] op);
      return {f7, rs2, rs1, f3, rd, op};
   endfunction

   function automatic word_t iFormat(logic [11:0] imm, regIdx_t rs1, logic [2:0] f3,
                                     regIdx_t rd, logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic word_t sFormat(logic [11:0] imm, regIdx_t rs2, regIdx_t rs1,
                                     logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], OpStore};
   endfunction

   function automatic word_t bFormat(logic [12:0] imm, regIdx_t rs2, regIdx_t rs1,
                                     logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OpBranch};
   endfunction

   function automatic word_t uFormat(logic [19:0] imm, regIdx_t rd, logic [6:0] op);
      return {imm, rd, op};
   endfunction

   function automatic word_t jFormat(logic [20:0] imm, regIdx_t rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OpJal};
   endfunction

   // Reference results
   function automatic word_t signExt12(logic [11:0] imm);
      return {{20{imm[11]}}, imm};
   endfunction

   function automatic word_t lessSigned(word_t a, word_t b);
      return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
   endfunction

   function automatic word_t lessUnsigned(word_t a, word_t b);
      return (a < b) ? 32'd1 : 32'd0;
   endfunction

   function automatic word_t shiftRightArith(word_t v, logic [4:0] n);
      logic signed [31:0] s;
      s = v;
      return s >>> n;
   endfunction

   function automatic bit branchTaken(logic [2:0] f3, word_t a, word_t b);
      case (f3)
         3'b000:  return a == b;
         3'b001:  return a != b;
         3'b100:  return $signed(a) < $signed(b);
         3'b101:  return $signed(a) >= $signed(b);
         3'b110:  return a < b;
         default: return a >= b;
      endcase
   endfunction

   function automatic word_t laneBits(logic [3:0] m);
      return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
   endfunction

   task automatic emit(word_t w);
      mem[progPc[11:2]] = w;
      progPc += 4;
   endtask

   // LUI plus ADDI, upper part rounded for the sign of the low 12 bits
   task automatic loadConst(regIdx_t rd, word_t value);
      word_t upper;
      upper = value + 32'h800;
      emit(uFormat(upper[31:12], rd, OpLui));
      emit(iFormat(value[11:0], rd, 3'b000, rd, OpImm));
   endtask

   task automatic expectStore(word_t addr, word_t data, logic [3:0] mask, word_t lanes);
      expAddr.push_back(addr);
      expData.push_back(data);
      expMask.push_back(mask);
      expLanes.push_back(lanes);
   endtask

   // SW rs into the next result slot through x30
   task automatic storeResult(regIdx_t rs, word_t value);
      emit(sFormat(resOff[11:0], rs, 5'd30, 3'b010));
      expectStore(ResultBase + resOff, value, 4'b1111, 32'hFFFF_FFFF);
      resOff += 4;
   endtask

   // Instruction writing x4, then its result stored
   task automatic runAndStore(word_t instr, word_t value);
      emit(instr);
      storeResult(5'd4, value);
   endtask

   task automatic markPath(logic [11:0] v);
      emit(iFormat(v, 5'd0, 3'b000, 5'd6, OpImm));
   endtask

   // Core held in reset while the program is written
   task automatic startProgram();
      @(negedge clk);
      reset = 1'b0;
      stallOn = 1'b0;
      for (int i = 0; i < 1024; i++) begin
         mem[i] = {16'h5A5A, 16'(i * 4)};
      end
      expAddr.delete();
      expData.delete();
      expMask.delete();
      expLanes.delete();
      progPc = `QUARK_RESET_ADDR;
      resOff = '0;
      emit(iFormat(12'h400, 5'd0, 3'b000, 5'd30, OpImm));
      emit(iFormat(12'h600, 5'd0, 3'b000, 5'd29, OpImm));
   endtask

   // Park in a self-loop, release reset, check the first fetch
   task automatic finishProgram();
      emit(jFormat(21'd0, 5'd0));
      repeat (3) @(negedge clk);
      seenAddr.delete();
      seenData.delete();
      seenMask.delete();
      reset = 1'b1;
      while (memRstrb !== 1'b1) @(negedge clk);
      checkMask(memWmask, 4'b0000, "write mask after reset");
      checkWord(memAddr, `QUARK_RESET_ADDR, "first fetch address");
   endtask

   // Watchdog covers a store that never comes
   task automatic collectAndCheck();
      while (seenAddr.size() < expAddr.size()) @(negedge clk);
      for (int i = 0; i < expAddr.size(); i++) begin
         checkWord(seenAddr[i], expAddr[i], $sformatf("store %0d address", i));
         checkMask(seenMask[i], expMask[i], $sformatf("store %0d write mask", i));
         checkWord(seenData[i] & expLanes[i], expData[i] & expLanes[i],
                   $sformatf("store %0d data", i));
      end
   endtask

   task automatic testArith(bit stalls);
      word_t a;
      word_t b;
      word_t c;
      a = 32'h1234_5678;
      b = 32'hFFFF_F00D;
      c = 32'h7FF0_0001;
      startProgram();
      stallOn = stalls;
      loadConst(5'd1, a);
      loadConst(5'd2, b);
      loadConst(5'd3, c);
      runAndStore(rFormat(7'h00, 5'd2, 5'd1, 3'b000, 5'd4, OpReg), a + b);
      runAndStore(rFormat(7'h20, 5'd2, 5'd1, 3'b000, 5'd4, OpReg), a - b);
      // Negative against positive, signed and unsigned disagree
      runAndStore(rFormat(7'h00, 5'd1, 5'd2, 3'b010, 5'd4, OpReg), lessSigned(b, a));
      runAndStore(rFormat(7'h00, 5'd1, 5'd2, 3'b011, 5'd4, OpReg), lessUnsigned(b, a));
      runAndStore(rFormat(7'h00, 5'd2, 5'd1, 3'b010, 5'd4, OpReg), lessSigned(a, b));
      runAndStore(rFormat(7'h00, 5'd2, 5'd1, 3'b011, 5'd4, OpReg), lessUnsigned(a, b));
      runAndStore(rFormat(7'h00, 5'd3, 5'd1, 3'b100, 5'd4, OpReg), a ^ c);
      runAndStore(rFormat(7'h00, 5'd3, 5'd1, 3'b110, 5'd4, OpReg), a | c);
      runAndStore(rFormat(7'h00, 5'd3, 5'd2, 3'b111, 5'd4, OpReg), b & c);
      runAndStore(iFormat(12'hFFB, 5'd1, 3'b000, 5'd4, OpImm), a + signExt12(12'hFFB));
      runAndStore(iFormat(12'hFFF, 5'd1, 3'b010, 5'd4, OpImm), lessSigned(a, 32'hFFFF_FFFF));
      runAndStore(iFormat(12'hFFF, 5'd1, 3'b011, 5'd4, OpImm),
                  lessUnsigned(a, 32'hFFFF_FFFF));
      runAndStore(iFormat(12'h555, 5'd2, 3'b100, 5'd4, OpImm), b ^ signExt12(12'h555));
      runAndStore(iFormat(12'h0F0, 5'd1, 3'b110, 5'd4, OpImm), a | signExt12(12'h0F0));
      runAndStore(iFormat(12'h8F0, 5'd1, 3'b111, 5'd4, OpImm), a & signExt12(12'h8F0));
      runAndStore(uFormat(20'hABCDE, 5'd4, OpLui), 32'hABCD_E000);
      runAndStore(uFormat(20'h00010, 5'd4, OpAuipc), progPc + 32'h0001_0000);
      finishProgram();
      collectAndCheck();
   endtask

   task automatic testShifts();
      word_t      v;
      int         amounts [4];
      logic [4:0] sh;
      v = 32'h8765_4321;
      amounts = '{0, 1, 13, 31};
      startProgram();
      loadConst(5'd1, v);
      foreach (amounts[k]) begin
         sh = 5'(amounts[k]);
         // x5 holds the amount for the register forms
         emit(iFormat({7'h00, sh}, 5'd0, 3'b000, 5'd5, OpImm));
         runAndStore(iFormat({7'h00, sh}, 5'd1, 3'b001, 5'd4, OpImm), v << sh);
         runAndStore(iFormat({7'h00, sh}, 5'd1, 3'b101, 5'd4, OpImm), v >> sh);
         runAndStore(iFormat({7'h20, sh}, 5'd1, 3'b101, 5'd4, OpImm), shiftRightArith(v, sh));
         runAndStore(rFormat(7'h00, 5'd5, 5'd1, 3'b001, 5'd4, OpReg), v << sh);
         runAndStore(rFormat(7'h00, 5'd5, 5'd1, 3'b101, 5'd4, OpReg), v >> sh);
         runAndStore(rFormat(7'h20, 5'd5, 5'd1, 3'b101, 5'd4, OpReg), shiftRightArith(v, sh));
      end
      finishProgram();
      collectAndCheck();
   endtask

   task automatic testControl();
      word_t      regVal [4];
      regIdx_t    lhs [3];
      regIdx_t    rhs [3];
      logic [2:0] kinds [6];
      word_t      base;
      regVal = '{32'd0, 32'hFFFF_FFFB, 32'd3, 32'd3};
      lhs = '{5'd2, 5'd1, 5'd2};
      rhs = '{5'd3, 5'd2, 5'd1};
      kinds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
      startProgram();
      loadConst(5'd1, regVal[1]);
      loadConst(5'd2, regVal[2]);
      loadConst(5'd3, regVal[3]);
      // Marker 1 when the branch skips ahead, 2 when it falls through
      foreach (kinds[k]) begin
         for (int p = 0; p < 3; p++) begin
            markPath(12'd1);
            emit(bFormat(13'd8, rhs[p], lhs[p], kinds[k]));
            markPath(12'd2);
            storeResult(5'd6, branchTaken(kinds[k], regVal[lhs[p]], regVal[rhs[p]]) ?
                              32'd1 : 32'd2);
         end
      end
      markPath(12'd1);
      base = progPc;
      emit(jFormat(21'd8, 5'd7));
      markPath(12'd2);
      storeResult(5'd7, base + 4);
      storeResult(5'd6, 32'd1);
      // JALR to base + 16, odd offset drops bit 0
      base = progPc;
      emit(uFormat(20'h00000, 5'd8, OpAuipc));
      markPath(12'd1);
      emit(iFormat(12'd17, 5'd8, 3'b000, 5'd7, OpJalr));
      markPath(12'd2);
      storeResult(5'd7, base + 12);
      storeResult(5'd6, 32'd1);
      // RDCYCLE, three ALU ops, RDCYCLE, at 3 cycles each
      emit(iFormat(12'hC00, 5'd0, 3'b010, 5'd9, OpSystem));
      emit(iFormat(12'd1, 5'd0, 3'b000, 5'd10, OpImm));
      emit(iFormat(12'd2, 5'd0, 3'b000, 5'd11, OpImm));
      emit(iFormat(12'd3, 5'd0, 3'b000, 5'd12, OpImm));
      emit(iFormat(12'hC00, 5'd0, 3'b010, 5'd13, OpSystem));
      runAndStore(rFormat(7'h20, 5'd9, 5'd13, 3'b000, 5'd4, OpReg), 32'd12);
      finishProgram();
      collectAndCheck();
   endtask

   task automatic testBytes();
      word_t      src;
      word_t      d;
      logic [3:0] m;
      logic [7:0] by;
      logic [15:0] hw;
      src = 32'hA1B2_C3D4;
      d = 32'h80F1_7F02;
      startProgram();
      mem[DataBase[11:2]] = d;
      loadConst(5'd1, src);
      // SB at every offset of the first result word
      for (int k = 0; k < 4; k++) begin
         m = 4'b0001 << k;
         emit(sFormat(12'(k), 5'd1, 5'd30, 3'b000));
         expectStore(ResultBase + word_t'(k), {4{src[7:0]}}, m, laneBits(m));
      end
      // SH at both halves of the second
      emit(sFormat(12'd4, 5'd1, 5'd30, 3'b001));
      expectStore(ResultBase + 4, {2{src[15:0]}}, 4'b0011, laneBits(4'b0011));
      emit(sFormat(12'd6, 5'd1, 5'd30, 3'b001));
      expectStore(ResultBase + 6, {2{src[15:0]}}, 4'b1100, laneBits(4'b1100));
      resOff = 32'd8;
      for (int k = 0; k < 4; k++) begin
         by = d[8*k +: 8];
         runAndStore(iFormat(12'(k), 5'd29, 3'b000, 5'd4, OpLoad), {{24{by[7]}}, by});
         runAndStore(iFormat(12'(k), 5'd29, 3'b100, 5'd4, OpLoad), {24'b0, by});
      end
      for (int k = 0; k < 4; k += 2) begin
         hw = d[8*k +: 16];
         runAndStore(iFormat(12'(k), 5'd29, 3'b001, 5'd4, OpLoad), {{16{hw[15]}}, hw});
         runAndStore(iFormat(12'(k), 5'd29, 3'b101, 5'd4, OpLoad), {16'b0, hw});
      end
      runAndStore(iFormat(12'd0, 5'd29, 3'b010, 5'd4, OpLoad), d);
      finishProgram();
      collectAndCheck();
   endtask

   // Hang detection sized from the instruction count
   initial begin
      #(TotalInstr * 40 * ClkPeriod);
      $display("Watchdog expired after %0d cycles, the core stopped making progress",
               TotalInstr * 40);
      $display("CHECKS FAILED");
      $fatal(1, "watchdog timeout");
   end

   initial begin
      void'($urandom(25252));
      reset = 1'b0;
      memRdata = '0;
      memRbusy = 1'b0;
      memWbusy = 1'b0;
      stallOn = 1'b0;
      rdWait = 0;
      wrWait = 0;
      testArith(1'b0);
      testShifts();
      testControl();
      testBytes();
      // Same program again under random read and write stalls
      testArith(1'b1);
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

/* quarkCore.f */
+incdir+verilog
verilog/quarkPkg.sv
verilog/quarkExecIf.sv
verilog/quarkRegFile.sv
verilog/quarkAlu.sv
verilog/quarkLoadStore.sv
verilog/quarkSequencer.sv
verilog/quarkCore.sv
testbench/quarkCoreTb.sv

/* Makefile */
# Verilator simulation of the quark core testbench

SIM = obj_dir/VquarkCoreTb

all: run

compile: $(SIM)

$(SIM): quarkCore.f verilog/*.sv verilog/*.svh testbench/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module quarkCoreTb \
		-f quarkCore.f -Mdir obj_dir -o VquarkCoreTb

# The log decides, the simulator exit code is not trusted alone
run: compile
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
